/* Bender.yml */
package:
  name: lsu_subsystem

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/lsu_pkg.sv
      - hdl/lsu_store_align.sv
      - hdl/mem_req_bridge.sv
      - hdl/sram_wb_master.sv
      - hdl/wb_data_ram.sv
      - hdl/lsu_load_extend.sv
      - hdl/lsu_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/tb_clkgen.sv
      - sim/tb_lsu_top.sv

/* hdl/lsu_load_extend.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_load_extend (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire lsu_pkg::lsu_op_e op,
  input  wire lsu_pkg::off_t    byte_off,
  input  wire                   read_finish,
  input  wire                   write_finish,
  input  wire                   fault_finish,
  input  wire lsu_pkg::word_t   mem_rdata,
  output logic                  done,
  output lsu_pkg::word_t        rdata,
  output logic                  fault
);

  import lsu_pkg::*;

  localparam int W = $bits(word_t);

  logic [7:0]  byte_v;
  logic [15:0] half_v;
  word_t       ext;

  always_comb
  begin
    // addressed byte and half out of the word
    byte_v = mem_rdata[8*byte_off +: 8];
    half_v = byte_off[1] ? mem_rdata[31:16] : mem_rdata[15:0];
    case (op)
      LB:      ext = {{(W-8){byte_v[7]}}, byte_v};
      LBU:     ext = {{(W-8){1'b0}}, byte_v};
      LH:      ext = {{(W-16){half_v[15]}}, half_v};
      LHU:     ext = {{(W-16){1'b0}}, half_v};
      default: ext = mem_rdata;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      done  <= 1'b0;
      fault <= 1'b0;
    end
    else
    begin
      // any finish ends the access
      done  <= read_finish || write_finish || fault_finish;
      fault <= fault_finish;
    end
  end

  // result word kept until the next load
  always_ff @(posedge clk)
  begin
    if (read_finish)
      rdata <= ext;
  end

  a_one_finish : assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({read_finish, write_finish, fault_finish}));

endmodule

`default_nettype wire

/* hdl/lsu_macros.svh */
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// data path and address width in bits
`define LSU_DATA_W 32

// data ram depth in 32-bit words
`define LSU_RAM_WORDS 256

// extra cycles the ram waits before ack
// 0 gives the fastest possible ack
`define LSU_RAM_WAIT 1

`endif

/* hdl/lsu_pkg.sv */
`default_nettype none

`include "lsu_macros.svh"

package lsu_pkg;

  // one data or address word
  typedef logic [`LSU_DATA_W-1:0] word_t;

  // one enable bit per byte lane
  typedef logic [`LSU_DATA_W/8-1:0] sel_t;

  // byte offset inside a word
  typedef logic [1:0] off_t;

  // load/store operations
  // bits [1:0] size, bit 2 unsigned load, bit 3 store
  typedef enum logic [3:0] {
    LB  = 4'b0000,
    LH  = 4'b0001,
    LW  = 4'b0010,
    LBU = 4'b0100,
    LHU = 4'b0101,
    SB  = 4'b1000,
    SH  = 4'b1001,
    SW  = 4'b1010
  } lsu_op_e;

endpackage

`default_nettype wire

/* hdl/lsu_store_align.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_store_align (
  input  wire lsu_pkg::lsu_op_e op,
  input  wire lsu_pkg::word_t   addr,
  input  wire lsu_pkg::word_t   wdata,
  output logic                  we,
  output lsu_pkg::sel_t         sel,
  output lsu_pkg::word_t        bus_addr,
  output lsu_pkg::word_t        bus_wdata,
  output logic                  misaligned
);

  import lsu_pkg::*;

  // bus only sees word addresses
  assign bus_addr = {addr[$bits(word_t)-1:2], 2'b00};

  always_comb
  begin
    we         = 1'b0;
    sel        = '1;
    bus_wdata  = wdata;
    misaligned = 1'b0;
    case (op)
      LB, LBU:
      begin
        // single lane picked by the offset
        sel = sel_t'(4'b0001 << addr[1:0]);
      end
      LH, LHU:
      begin
        sel        = addr[1] ? sel_t'(4'b1100) : sel_t'(4'b0011);
        misaligned = addr[0];
      end
      LW:
      begin
        misaligned = |addr[1:0];
      end
      SB:
      begin
        we        = 1'b1;
        sel       = sel_t'(4'b0001 << addr[1:0]);
        // byte copied to every lane, sel picks the real one
        bus_wdata = {4{wdata[7:0]}};
      end
      SH:
      begin
        we         = 1'b1;
        sel        = addr[1] ? sel_t'(4'b1100) : sel_t'(4'b0011);
        bus_wdata  = {2{wdata[15:0]}};
        misaligned = addr[0];
      end
      SW:
      begin
        we         = 1'b1;
        misaligned = |addr[1:0];
      end
      default:
      begin
        // unknown op treated as a plain word load
        we = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* hdl/lsu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   enable,
  input  wire lsu_pkg::lsu_op_e op,
  input  wire lsu_pkg::word_t   addr,
  input  wire lsu_pkg::word_t   wdata,
  output logic                  done,
  output lsu_pkg::word_t        rdata,
  output logic                  fault
);

  import lsu_pkg::*;

  // alignment stage outputs
  logic  al_we;
  sel_t  al_sel;
  word_t al_addr;
  word_t al_wdata;
  logic  al_misaligned;

  // sram-like bus
  logic  s_req;
  logic  s_wr;
  sel_t  s_select;
  word_t s_addr;
  word_t s_wdata;
  logic  s_addr_ok;
  logic  s_data_ok;
  word_t s_rdata;

  // bridge to load stage
  logic  write_finish;
  logic  read_finish;
  logic  fault_finish;
  word_t mem_rdata;

  // wishbone
  logic  wb_cyc;
  logic  wb_stb;
  logic  wb_we;
  word_t wb_adr;
  sel_t  wb_sel;
  word_t wb_dat_w;
  logic  wb_ack;
  word_t wb_dat_r;

  lsu_store_align lsu_store_align_inst (
    .op         (op),
    .addr       (addr),
    .wdata      (wdata),
    .we         (al_we),
    .sel        (al_sel),
    .bus_addr   (al_addr),
    .bus_wdata  (al_wdata),
    .misaligned (al_misaligned)
  );

  mem_req_bridge mem_req_bridge_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable       (enable),
    .we           (al_we),
    .sel          (al_sel),
    .bus_addr     (al_addr),
    .bus_wdata    (al_wdata),
    .misaligned   (al_misaligned),
    .addr_ok      (s_addr_ok),
    .data_ok      (s_data_ok),
    .rdata        (s_rdata),
    .req          (s_req),
    .wr           (s_wr),
    .select       (s_select),
    .addr         (s_addr),
    .wdata        (s_wdata),
    .write_finish (write_finish),
    .read_finish  (read_finish),
    .fault_finish (fault_finish),
    .mem_rdata    (mem_rdata)
  );

  sram_wb_master sram_wb_master_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .req     (s_req),
    .wr      (s_wr),
    .select  (s_select),
    .addr    (s_addr),
    .wdata   (s_wdata),
    .addr_ok (s_addr_ok),
    .data_ok (s_data_ok),
    .rdata   (s_rdata),
    .ack     (wb_ack),
    .dat_r   (wb_dat_r),
    .cyc     (wb_cyc),
    .stb     (wb_stb),
    .wb_we   (wb_we),
    .adr     (wb_adr),
    .wb_sel  (wb_sel),
    .dat_w   (wb_dat_w)
  );

  wb_data_ram wb_data_ram_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .cyc   (wb_cyc),
    .stb   (wb_stb),
    .we    (wb_we),
    .adr   (wb_adr),
    .sel   (wb_sel),
    .dat_w (wb_dat_w),
    .ack   (wb_ack),
    .dat_r (wb_dat_r)
  );

  // op and addr are still held by the core when the data returns
  lsu_load_extend lsu_load_extend_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .op           (op),
    .byte_off     (addr[1:0]),
    .read_finish  (read_finish),
    .write_finish (write_finish),
    .fault_finish (fault_finish),
    .mem_rdata    (mem_rdata),
    .done         (done),
    .rdata        (rdata),
    .fault        (fault)
  );

endmodule

`default_nettype wire

/* hdl/mem_req_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_req_bridge (
  input  wire                 clk,
  input  wire                 rst_n,
  // held request from the alignment stage
  input  wire                 enable,
  input  wire                 we,
  input  wire lsu_pkg::sel_t  sel,
  input  wire lsu_pkg::word_t bus_addr,
  input  wire lsu_pkg::word_t bus_wdata,
  input  wire                 misaligned,
  // sram-like side
  input  wire                 addr_ok,
  input  wire                 data_ok,
  input  wire lsu_pkg::word_t rdata,
  output logic                req,
  output logic                wr,
  output lsu_pkg::sel_t       select,
  output lsu_pkg::word_t      addr,
  output lsu_pkg::word_t      wdata,
  // completion towards the load stage
  output logic                write_finish,
  output logic                read_finish,
  output logic                fault_finish,
  output lsu_pkg::word_t      mem_rdata
);

  import lsu_pkg::*;

  // set once the master took the request, held for the rest of the enable window
  logic accepted;
  // set once the fault finish went out for a misaligned access
  logic fault_sent;

  // one request per enable window, none for a misaligned access
  assign req = enable && !misaligned && !accepted;

  assign wr     = we;
  assign select = sel;
  assign addr   = bus_addr;
  assign wdata  = bus_wdata;

  // data_ok split by direction
  assign write_finish = enable && we && data_ok;
  assign read_finish  = enable && !we && data_ok;
  assign mem_rdata    = rdata;

  // fault finishes in the first enable cycle, no bus cycle
  assign fault_finish = enable && misaligned && !fault_sent;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      accepted   <= 1'b0;
      fault_sent <= 1'b0;
    end
    else if (!enable)
    begin
      // core dropped enable, ready for the next access
      accepted   <= 1'b0;
      fault_sent <= 1'b0;
    end
    else
    begin
      if (addr_ok)
        accepted <= 1'b1;
      if (fault_finish)
        fault_sent <= 1'b1;
    end
  end

  // a request the master took is not raised again right after
  a_single_issue : assert property (@(posedge clk) disable iff (!rst_n)
    (req && addr_ok) |=> !req);

  // the master only answers a request it accepted earlier
  a_data_after_accept : assert property (@(posedge clk) disable iff (!rst_n)
    data_ok |-> accepted);

endmodule

`default_nettype wire

/* hdl/sram_wb_master.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_wb_master (
  input  wire                 clk,
  input  wire                 rst_n,
  // sram-like slave side
  input  wire                 req,
  input  wire                 wr,
  input  wire lsu_pkg::sel_t  select,
  input  wire lsu_pkg::word_t addr,
  input  wire lsu_pkg::word_t wdata,
  output logic                addr_ok,
  output logic                data_ok,
  output lsu_pkg::word_t      rdata,
  // wishbone classic master side
  input  wire                 ack,
  input  wire lsu_pkg::word_t dat_r,
  output logic                cyc,
  output logic                stb,
  output logic                wb_we,
  output lsu_pkg::word_t      adr,
  output lsu_pkg::sel_t       wb_sel,
  output lsu_pkg::word_t      dat_w
);

  import lsu_pkg::*;

  typedef enum logic {
    ST_IDLE,
    ST_BUSY
  } state_e;

  state_e state;

  // request captured at acceptance
  logic  wr_q;
  sel_t  sel_q;
  word_t addr_q;
  word_t wdata_q;

  // take a new request only while no cycle is open
  assign addr_ok = (state == ST_IDLE) && req;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state <= ST_IDLE;
    end
    else
    begin
      case (state)
        ST_IDLE:
          if (addr_ok)
            state <= ST_BUSY;
        ST_BUSY:
          // cycle closes on the edge that samples ack
          if (ack)
            state <= ST_IDLE;
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (addr_ok)
    begin
      wr_q    <= wr;
      sel_q   <= select;
      addr_q  <= addr;
      wdata_q <= wdata;
    end
  end

  // classic cycle, cyc and stb together for the whole transfer
  assign cyc    = (state == ST_BUSY);
  assign stb    = (state == ST_BUSY);
  assign wb_we  = wr_q;
  assign adr    = addr_q;
  assign wb_sel = sel_q;
  assign dat_w  = wdata_q;

  // answer in the ack cycle, read data passes straight through
  assign data_ok = cyc && ack;
  assign rdata   = dat_r;

  // slave answers only a strobed cycle
  a_ack_in_cycle : assert property (@(posedge clk) disable iff (!rst_n)
    ack |-> (cyc && stb));

  // once open, the transfer waits unchanged for the slave
  a_hold_until_ack : assert property (@(posedge clk) disable iff (!rst_n)
    (stb && !ack) |=> (stb && $stable({wb_we, adr, wb_sel, dat_w})));

endmodule

`default_nettype wire

/* hdl/wb_data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_macros.svh"

module wb_data_ram (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire                 cyc,
  input  wire                 stb,
  input  wire                 we,
  input  wire lsu_pkg::word_t adr,
  input  wire lsu_pkg::sel_t  sel,
  input  wire lsu_pkg::word_t dat_w,
  output logic                ack,
  output lsu_pkg::word_t      dat_r
);

  import lsu_pkg::*;

  localparam int WORDS  = `LSU_RAM_WORDS;
  localparam int WAIT   = `LSU_RAM_WAIT;
  localparam int AW     = $clog2(WORDS);
  // counter needs at least one bit even with no wait states
  localparam int CW     = (WAIT > 0) ? $clog2(WAIT + 1) : 1;
  localparam int LANES  = $bits(sel_t);

  word_t mem [WORDS];

  logic [CW-1:0] wait_cnt;
  logic [AW-1:0] idx;
  logic          pending;
  logic          last;

  // word index from the byte address
  assign idx = adr[AW+1:2];

  // open cycle not yet answered
  assign pending = cyc && stb && !ack;
  assign last    = (wait_cnt == CW'(WAIT));

  initial
  begin
    for (int i = 0; i < WORDS; i++)
      mem[i] = '0;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      ack      <= 1'b0;
      wait_cnt <= '0;
    end
    else
    begin
      // ack is a single cycle, the master drops stb with it
      ack <= pending && last;
      if (pending && !last)
        wait_cnt <= wait_cnt + 1'b1;
      else
        wait_cnt <= '0;
    end
  end

  // write lands and read data shows up in the ack cycle
  always_ff @(posedge clk)
  begin
    if (pending && last)
    begin
      if (we)
      begin
        for (int b = 0; b < LANES; b++)
        begin
          if (sel[b])
            mem[idx][8*b +: 8] <= dat_w[8*b +: 8];
        end
      end
      dat_r <= mem[idx];
    end
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+hdl
hdl/lsu_pkg.sv
hdl/lsu_store_align.sv
hdl/mem_req_bridge.sv
hdl/sram_wb_master.sv
hdl/wb_data_ram.sv
hdl/lsu_load_extend.sv
hdl/lsu_top.sv
sim/tb_clkgen.sv
sim/tb_lsu_top.sv

/* sim/tb_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
  parameter real PERIOD_NS    = 8.0,
  parameter int  RESET_CYCLES = 10
) (
  output logic clk,
  output logic rst_n
);

  // free running clock
  initial
  begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;
  end

  // reset held over the first rising edges, released away from them
  initial
  begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* sim/tb_lsu_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_macros.svh"

module tb_lsu_top;

  import lsu_pkg::*;

  localparam int RESET_CYCLES     = 10;
  // enable sampled high to done sampled high
  localparam int ACCESS_CYCLES    = 3 + `LSU_RAM_WAIT;
  localparam int RANDOM_ACCESSES  = 40;
  // 2 + 14 + 13 + 6 + 3 directed, plus the random run
  localparam int PLANNED_ACCESSES = 38 + RANDOM_ACCESSES;
  localparam int CYCLE_LIMIT      = 20 * PLANNED_ACCESSES + RESET_CYCLES;

  logic    clk;
  logic    rst_n;
  logic    enable;
  lsu_op_e op;
  word_t   addr;
  word_t   wdata;
  logic    done;
  word_t   rdata;
  logic    fault;

  int value_errors;
  int other_errors;
  int cycle_count;

  // expected memory contents, word granular like the ram
  word_t model_mem [`LSU_RAM_WORDS];

  tb_clkgen #(
    .PERIOD_NS    (8.0),
    .RESET_CYCLES (RESET_CYCLES)
  ) tb_clkgen_inst (
    .clk   (clk),
    .rst_n (rst_n)
  );

  lsu_top lsu_top_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .enable (enable),
    .op     (op),
    .addr   (addr),
    .wdata  (wdata),
    .done   (done),
    .rdata  (rdata),
    .fault  (fault)
  );

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      value_errors++;
    end
  endtask

  function automatic logic is_store(input lsu_op_e op_i);
    return op_i inside {SB, SH, SW};
  endfunction

  // halves need an even address, words a 4-byte boundary
  function automatic logic is_misaligned(input lsu_op_e op_i, input word_t addr_i);
    if (op_i inside {LH, LHU, SH})
      return addr_i[0];
    if (op_i inside {LW, SW})
      return addr_i[1:0] != 2'b00;
    return 1'b0;
  endfunction

  function automatic int word_index(input word_t addr_i);
    return (addr_i >> 2) % `LSU_RAM_WORDS;
  endfunction

  task automatic model_store(input lsu_op_e op_i, input word_t addr_i, input word_t data_i);
    word_t w;
    w = model_mem[word_index(addr_i)];
    case (op_i)
      SB: w[8*addr_i[1:0] +: 8] = data_i[7:0];
      SH: w[16*addr_i[1] +: 16] = data_i[15:0];
      default: w = data_i;
    endcase
    model_mem[word_index(addr_i)] = w;
  endtask

  function automatic word_t model_load(input lsu_op_e op_i, input word_t addr_i);
    word_t       w;
    logic [7:0]  b;
    logic [15:0] h;
    w = model_mem[word_index(addr_i)];
    b = w[8*addr_i[1:0] +: 8];
    h = w[16*addr_i[1] +: 16];
    case (op_i)
      LB:      return {{24{b[7]}}, b};
      LBU:     return {24'h0, b};
      LH:      return {{16{h[15]}}, h};
      LHU:     return {16'h0, h};
      default: return w;
    endcase
  endfunction

  function automatic lsu_op_e pick_op(input int k);
    case (k)
      0:       return LB;
      1:       return LBU;
      2:       return LH;
      3:       return LHU;
      4:       return LW;
      5:       return SB;
      6:       return SH;
      default: return SW;
    endcase
  endfunction

  // one full access: raise enable, wait for done, optional hold, one idle cycle
  task automatic do_access(
    input  lsu_op_e op_i,
    input  word_t   addr_i,
    input  word_t   wdata_i,
    input  int      hold_cycles,
    output word_t   rdata_o
  );
    logic  bad;
    logic  seen;
    int    expected_lat;
    int    n;
    word_t exp_rdata;
    bad          = is_misaligned(op_i, addr_i);
    expected_lat = bad ? 1 : ACCESS_CYCLES;
    exp_rdata    = '0;
    if (!bad && !is_store(op_i))
      exp_rdata = model_load(op_i, addr_i);
    op     = op_i;
    addr   = addr_i;
    wdata  = wdata_i;
    enable = 1'b1;
    n      = 0;
    seen   = 1'b0;
    // done must stay low until exactly the expected cycle
    while (!seen && n < ACCESS_CYCLES)
    begin
      @(negedge clk);
      n++;
      check_flag("done", done, n == expected_lat);
      seen = done;
    end
    if (!seen)
    begin
      $display("ERROR: %s at 0x%08h gave no done pulse within %0d cycles",
               op_i.name(), addr_i, ACCESS_CYCLES);
      other_errors++;
    end
    check_flag("fault", fault, bad);
    rdata_o = rdata;
    if (!bad && !is_store(op_i))
      check_word("rdata", rdata, exp_rdata);
    if (!bad && is_store(op_i))
      model_store(op_i, addr_i, wdata_i);
    // enable still held, no second completion allowed
    repeat (hold_cycles)
    begin
      @(negedge clk);
      check_flag("done", done, 1'b0);
    end
    enable = 1'b0;
    @(negedge clk);
    check_flag("done", done, 1'b0);
  endtask

  task automatic test_word_roundtrip();
    word_t r;
    do_access(SW, 32'h40, 32'hDEAD_BEEF, 0, r);
    do_access(LW, 32'h40, 32'h0, 0, r);
    check_word("rdata", r, 32'hDEAD_BEEF);
  endtask

  task automatic test_byte_half_lanes();
    word_t r;
    do_access(SW, 32'h80, 32'h1122_3344, 0, r);
    // each byte store touches one lane only
    for (int k = 0; k < 4; k++)
    begin
      do_access(SB, 32'h80 + k, 32'hFFFF_FFA0 + k, 0, r);
      do_access(LW, 32'h80, 32'h0, 0, r);
    end
    check_word("rdata", r, 32'hA3A2_A1A0);
    do_access(SW, 32'h84, 32'h1122_3344, 0, r);
    do_access(SH, 32'h84, 32'h5555_BEEF, 0, r);
    do_access(LW, 32'h84, 32'h0, 0, r);
    check_word("rdata", r, 32'h1122_BEEF);
    do_access(SH, 32'h86, 32'h0000_CAFE, 0, r);
    do_access(LW, 32'h84, 32'h0, 0, r);
    check_word("rdata", r, 32'hCAFE_BEEF);
  endtask

  task automatic test_load_extension();
    word_t r;
    // every byte and half has its top bit set
    do_access(SW, 32'h100, 32'h80F1_9C85, 0, r);
    for (int k = 0; k < 4; k++)
    begin
      do_access(LB, 32'h100 + k, 32'h0, 0, r);
      check_word("rdata upper", r & 32'hFFFF_FF00, 32'hFFFF_FF00);
      do_access(LBU, 32'h100 + k, 32'h0, 0, r);
      check_word("rdata upper", r & 32'hFFFF_FF00, 32'h0);
    end
    for (int k = 0; k < 4; k += 2)
    begin
      do_access(LH, 32'h100 + k, 32'h0, 0, r);
      check_word("rdata upper", r & 32'hFFFF_0000, 32'hFFFF_0000);
      do_access(LHU, 32'h100 + k, 32'h0, 0, r);
      check_word("rdata upper", r & 32'hFFFF_0000, 32'h0);
    end
  endtask

  task automatic test_misaligned();
    word_t r;
    do_access(SW, 32'h200, 32'h0BAD_F00D, 0, r);
    do_access(SH, 32'h201, 32'hFFFF_FFFF, 0, r);
    do_access(SW, 32'h202, 32'hFFFF_FFFF, 0, r);
    do_access(LH, 32'h203, 32'h0, 0, r);
    do_access(LW, 32'h201, 32'h0, 0, r);
    // faulted stores must not have written
    do_access(LW, 32'h200, 32'h0, 0, r);
    check_word("rdata", r, 32'h0BAD_F00D);
  endtask

  task automatic test_hold_enable();
    word_t r;
    do_access(SW, 32'h300, 32'h1357_9BDF, 4, r);
    do_access(LW, 32'h300, 32'h0, 4, r);
    check_word("rdata", r, 32'h1357_9BDF);
    do_access(LW, 32'h302, 32'h0, 3, r);
  endtask

  task automatic test_random_traffic();
    lsu_op_e op_r;
    word_t   a;
    word_t   d;
    word_t   r;
    for (int i = 0; i < RANDOM_ACCESSES; i++)
    begin
      op_r = pick_op($urandom % 8);
      // small window so loads hit earlier stores
      a = word_t'($urandom % 64);
      if (op_r inside {LH, LHU, SH})
        a[0] = 1'b0;
      else if (op_r inside {LW, SW})
        a[1:0] = 2'b00;
      d = $urandom;
      do_access(op_r, a, d, 0, r);
    end
  endtask

  // hard stop in case the DUT never answers
  initial
  begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT)
    begin
      @(posedge clk);
      cycle_count++;
    end
    $display("ERROR: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial
  begin
    enable       = 1'b0;
    op           = LW;
    addr         = '0;
    wdata        = '0;
    value_errors = 0;
    other_errors = 0;
    void'($urandom(32'h6f40_1336));
    // ram powers up cleared
    for (int i = 0; i < `LSU_RAM_WORDS; i++)
      model_mem[i] = '0;

    wait (rst_n === 1'b1);
    @(negedge clk);
    check_flag("done", done, 1'b0);
    check_flag("fault", fault, 1'b0);

    test_word_roundtrip();
    test_byte_half_lanes();
    test_load_extension();
    test_misaligned();
    test_hold_enable();
    test_random_traffic();

    $display("errors: %0d value mismatches, %0d other failures",
             value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire
